//--- src/datapath_pkg.sv
package datapath_pkg;

    // register count and width of the IR constant field
    localparam int num_gprs     = 16;
    localparam int c_field_bits = 19;

    // one bus word, also the width of every register
    typedef logic [31:0] word_t;

    typedef enum logic [4:0] {
        add    = 5'd0,
        sub    = 5'd1,
        and_op = 5'd2,
        or_op  = 5'd3,
        shr    = 5'd4,
        shra   = 5'd5,
        shl    = 5'd6,
        ror    = 5'd7,
        rol    = 5'd8,
        mul    = 5'd9,
        neg    = 5'd10,
        not_op = 5'd11
    } alu_op_e;

    // bus sources, lowest value wins when several drive flags are set
    typedef enum logic [4:0] {
        gpr0, gpr1, gpr2, gpr3, gpr4, gpr5, gpr6, gpr7,
        gpr8, gpr9, gpr10, gpr11, gpr12, gpr13, gpr14, gpr15,
        hi, lo, zhi, zlo, pc, mdr, inport, c_ext,
        none
    } bus_src_e;

    typedef struct packed {
        logic [num_gprs-1:0] gpr_out;
        logic                hi_out;
        logic                lo_out;
        logic                zhi_out;
        logic                zlo_out;
        logic                pc_out;
        logic                mdr_out;
        logic                inport_out;
        logic                c_out;
    } drive_t;

    typedef struct packed {
        logic [num_gprs-1:0] gpr_in;
        logic                y_in;
        logic                hi_in;
        logic                lo_in;
        logic                z_in;
        logic                pc_in;
        logic                pc_increment;
        logic                ir_in;
        logic                mar_in;
        logic                mdr_in;
        logic                read;
    } load_t;

    // one control word per cycle
    typedef struct packed {
        drive_t  drive;
        load_t   load;
        alu_op_e op;
    } ctrl_t;

    // 64-bit ALU result as it lands in the Z pair
    typedef struct packed {
        word_t high;
        word_t low;
    } alu_result_t;

endpackage

//--- src/register_file.sv
`timescale 1ns/1ps

module register_file
    import datapath_pkg::*;
(
    input  logic                clk,
    input  logic                reset,
    input  logic [num_gprs-1:0] gpr_in,
    input  word_t               bus,
    output word_t               gpr_data [num_gprs]
);

    // r0 to r15, each with its own load strobe from the bus
    always_ff @(posedge clk) begin
        for (int i = 0; i < num_gprs; i++) begin
            if (reset) begin
                gpr_data[i] <= '0;
            end else if (gpr_in[i]) begin
                gpr_data[i] <= bus;
            end
        end
    end

endmodule

//--- src/bus_driver.sv
`timescale 1ns/1ps

module bus_driver
    import datapath_pkg::*;
(
    input  drive_t drive,
    input  word_t  gpr_data [num_gprs],
    input  word_t  hi_data,
    input  word_t  lo_data,
    input  word_t  zhi_data,
    input  word_t  zlo_data,
    input  word_t  pc_data,
    input  word_t  mdr_data,
    input  word_t  inport_data,
    input  word_t  c_ext_data,
    output word_t  bus
);

    // flag bit i belongs to the source whose bus_src_e value is i
    logic [int'(none)-1:0] flags;
    bus_src_e              sel;

    assign flags = {
        drive.c_out,
        drive.inport_out,
        drive.mdr_out,
        drive.pc_out,
        drive.zlo_out,
        drive.zhi_out,
        drive.lo_out,
        drive.hi_out,
        drive.gpr_out
    };

    // scan from the low-priority end so the highest-priority flag is written last
    always_comb begin
        sel = none;
        for (int i = int'(none) - 1; i >= 0; i--) begin
            if (flags[i]) begin
                sel = bus_src_e'(5'(i));
            end
        end
    end

    // source select, zero when nothing drives
    always_comb begin
        if (sel <= gpr15) begin
            bus = gpr_data[sel[3:0]];
        end else begin
            case (sel)
                hi:      bus = hi_data;
                lo:      bus = lo_data;
                zhi:     bus = zhi_data;
                zlo:     bus = zlo_data;
                pc:      bus = pc_data;
                mdr:     bus = mdr_data;
                inport:  bus = inport_data;
                c_ext:   bus = c_ext_data;
                default: bus = '0;
            endcase
        end
    end

endmodule

//--- src/alu.sv
`timescale 1ns/1ps

module alu
    import datapath_pkg::*;
(
    input  alu_op_e     op,
    input  word_t       a,
    input  word_t       b,
    output alu_result_t result
);

    // shift and rotate distance
    logic [4:0]         amt;
    logic signed [63:0] product;
    word_t              ror_val;
    word_t              rol_val;

    assign amt = b[4:0];

    // full signed product for mul
    assign product = $signed(a) * $signed(b);

    // a zero distance leaves the word unchanged, the far shift then gives zero
    assign ror_val = (a >> amt) | (a << (6'd32 - {1'b0, amt}));
    assign rol_val = (a << amt) | (a >> (6'd32 - {1'b0, amt}));

    always_comb begin
        result = '0;
        case (op)
            add: begin
                result.low = a + b;
            end
            sub: begin
                result.low = a - b;
            end
            and_op: begin
                result.low = a & b;
            end
            or_op: begin
                result.low = a | b;
            end
            shr: begin
                result.low = a >> amt;
            end
            shra: begin
                result.low = word_t'($signed(a) >>> amt);
            end
            shl: begin
                result.low = a << amt;
            end
            ror: begin
                result.low = ror_val;
            end
            rol: begin
                result.low = rol_val;
            end
            mul: begin
                result = alu_result_t'(product);
            end
            // unary ops take the bus operand, Y is ignored
            neg: begin
                result.low = -b;
            end
            not_op: begin
                result.low = ~b;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

//--- src/special_registers.sv
`timescale 1ns/1ps

module special_registers
    import datapath_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  load_t       load,
    input  word_t       bus,
    input  alu_result_t alu_result,
    output word_t       y_data,
    output word_t       hi_data,
    output word_t       lo_data,
    output word_t       zhi_data,
    output word_t       zlo_data,
    output word_t       pc_data,
    output word_t       ir_data,
    output word_t       c_ext_data
);

    // bus-loaded registers and the Z pair
    always_ff @(posedge clk) begin
        if (reset) begin
            y_data   <= '0;
            hi_data  <= '0;
            lo_data  <= '0;
            zhi_data <= '0;
            zlo_data <= '0;
            ir_data  <= '0;
        end else begin
            if (load.y_in) begin
                y_data <= bus;
            end
            if (load.hi_in) begin
                hi_data <= bus;
            end
            if (load.lo_in) begin
                lo_data <= bus;
            end
            // Z takes the ALU result, never the bus
            if (load.z_in) begin
                zhi_data <= alu_result.high;
                zlo_data <= alu_result.low;
            end
            if (load.ir_in) begin
                ir_data <= bus;
            end
        end
    end

    // pc_in beats pc_increment
    always_ff @(posedge clk) begin
        if (reset) begin
            pc_data <= '0;
        end else if (load.pc_in) begin
            pc_data <= bus;
        end else if (load.pc_increment) begin
            pc_data <= pc_data + 32'd1;
        end
    end

    // IR constant field, sign-extended
    assign c_ext_data = {
        {($bits(word_t) - c_field_bits){ir_data[c_field_bits-1]}},
        ir_data[c_field_bits-1:0]
    };

endmodule

//--- src/memory_interface.sv
`timescale 1ns/1ps

module memory_interface
    import datapath_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  mar_in,
    input  logic  mdr_in,
    input  logic  read,
    input  word_t bus,
    input  word_t mem_data_in,
    output word_t mar_data,
    output word_t mdr_data
);

    // MDR input select, memory during a read
    word_t mdr_next;

    assign mdr_next = read ? mem_data_in : bus;

    always_ff @(posedge clk) begin
        if (reset) begin
            mar_data <= '0;
        end else if (mar_in) begin
            mar_data <= bus;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mdr_data <= '0;
        end else if (mdr_in) begin
            mdr_data <= mdr_next;
        end
    end

endmodule

//--- src/datapath.sv
`timescale 1ns/1ps

module datapath
    import datapath_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  ctrl_t ctrl,
    input  word_t mem_data_in,
    input  word_t inport_data,
    output word_t bus_data,
    output word_t mem_addr,
    output word_t mem_wdata,
    output word_t ir_data
);

    // register contents heading to the bus
    word_t       gpr_data [num_gprs];
    word_t       y_data;
    word_t       hi_data;
    word_t       lo_data;
    word_t       zhi_data;
    word_t       zlo_data;
    word_t       pc_data;
    word_t       c_ext_data;
    alu_result_t alu_result;

    register_file register_file_inst (
        .clk      (clk),
        .reset    (reset),
        .gpr_in   (ctrl.load.gpr_in),
        .bus      (bus_data),
        .gpr_data (gpr_data)
    );

    // MDR doubles as the bus source and the memory write data
    bus_driver bus_driver_inst (
        .drive       (ctrl.drive),
        .gpr_data    (gpr_data),
        .hi_data     (hi_data),
        .lo_data     (lo_data),
        .zhi_data    (zhi_data),
        .zlo_data    (zlo_data),
        .pc_data     (pc_data),
        .mdr_data    (mem_wdata),
        .inport_data (inport_data),
        .c_ext_data  (c_ext_data),
        .bus         (bus_data)
    );

    alu alu_inst (
        .op     (ctrl.op),
        .a      (y_data),
        .b      (bus_data),
        .result (alu_result)
    );

    special_registers special_registers_inst (
        .clk        (clk),
        .reset      (reset),
        .load       (ctrl.load),
        .bus        (bus_data),
        .alu_result (alu_result),
        .y_data     (y_data),
        .hi_data    (hi_data),
        .lo_data    (lo_data),
        .zhi_data   (zhi_data),
        .zlo_data   (zlo_data),
        .pc_data    (pc_data),
        .ir_data    (ir_data),
        .c_ext_data (c_ext_data)
    );

    memory_interface memory_interface_inst (
        .clk         (clk),
        .reset       (reset),
        .mar_in      (ctrl.load.mar_in),
        .mdr_in      (ctrl.load.mdr_in),
        .read        (ctrl.load.read),
        .bus         (bus_data),
        .mem_data_in (mem_data_in),
        .mar_data    (mem_addr),
        .mdr_data    (mem_wdata)
    );

endmodule

//--- sim/datapath_tb.sv
`timescale 1ns/1ps

module datapath_tb
    import datapath_pkg::*;
();

    // which expectations of a row apply
    localparam logic [3:0] m_bus   = 4'b0001;
    localparam logic [3:0] m_addr  = 4'b0010;
    localparam logic [3:0] m_wdata = 4'b0100;
    localparam logic [3:0] m_ir    = 4'b1000;

    // one table row, driven for one clock cycle
    typedef struct packed {
        int         test;
        logic       rst;
        ctrl_t      ctrl;
        word_t      mem;
        word_t      inport;
        word_t      bus;
        word_t      addr;
        word_t      wdata;
        word_t      ir;
        logic [3:0] mask;
    } step_t;

    logic  clk;
    logic  reset;
    ctrl_t ctrl;
    word_t mem_data_in;
    word_t inport_data;
    word_t bus_data;
    word_t mem_addr;
    word_t mem_wdata;
    word_t ir_data;

    step_t steps [$];
    string test_names [6] = '{"memory load", "alu ops", "pc and mar",
                              "bus priority", "ir constant", "reset"};
    int    cur_test;
    int    cycles;
    int    cycle_limit = 0;
    int    errors = 0;
    int    checks = 0;
    int    test_errors = 0;
    int    test_checks = 0;
    int    tests_run = 0;

    datapath datapath_inst (
        .clk         (clk),
        .reset       (reset),
        .ctrl        (ctrl),
        .mem_data_in (mem_data_in),
        .inport_data (inport_data),
        .bus_data    (bus_data),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .ir_data     (ir_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // expected ALU result, high word in the upper half
    function automatic logic [63:0] alu_model(alu_op_e op, word_t a, word_t b);
        int          sh;
        logic [63:0] both;
        longint      sa;
        longint      sb;
        sh = int'(b[4:0]);
        sa = longint'($signed(a));
        sb = longint'($signed(b));
        case (op)
            add:    return {32'h0, a + b};
            sub:    return {32'h0, a - b};
            and_op: return {32'h0, a & b};
            or_op:  return {32'h0, a | b};
            shr:    return {32'h0, a >> sh};
            shl:    return {32'h0, a << sh};
            shra: begin
                both = {{32{a[31]}}, a} >> sh;
                return {32'h0, both[31:0]};
            end
            // rotates through a doubled copy of the word
            ror: begin
                both = {a, a} >> sh;
                return {32'h0, both[31:0]};
            end
            rol: begin
                both = {a, a} << sh;
                return {32'h0, both[63:32]};
            end
            mul:    return sa * sb;
            neg:    return {32'h0, 32'h0 - b};
            not_op: return {32'h0, ~b};
            default: return '0;
        endcase
    endfunction

    // 19-bit constant field with its sign copied upward
    function automatic word_t c_extend(word_t w);
        if (w[18]) begin
            return w | 32'hfff8_0000;
        end else begin
            return w & 32'h0007_ffff;
        end
    endfunction

    task automatic add_step(input ctrl_t c, input word_t mem, input word_t inport,
                            input logic [3:0] mask, input word_t e_bus, input word_t e_addr,
                            input word_t e_wdata, input word_t e_ir);
        step_t s;
        s = '0;
        s.test = cur_test;
        s.ctrl = c;
        s.mem = mem;
        s.inport = inport;
        s.mask = mask;
        s.bus = e_bus;
        s.addr = e_addr;
        s.wdata = e_wdata;
        s.ir = e_ir;
        steps.push_back(s);
    endtask

    task automatic bus_step(input ctrl_t c, input word_t inport, input word_t e_bus);
        add_step(c, '0, inport, m_bus, e_bus, '0, '0, '0);
    endtask

    task automatic reset_step();
        step_t s;
        s = '0;
        s.test = cur_test;
        s.rst = 1'b1;
        steps.push_back(s);
    endtask

    task automatic build_table();
        ctrl_t       c;
        word_t       m;
        word_t       a;
        word_t       b;
        word_t       p;
        word_t       q;
        word_t       h;
        word_t       l;
        word_t       w;
        word_t       i_neg;
        word_t       i_pos;
        logic [63:0] r;
        alu_op_e     ops [12];
        ops = '{add, sub, and_op, or_op, shr, shra, shl, ror, rol, mul, neg, not_op};

        // memory word through MDR into r3 and back
        cur_test = 0;
        m = $urandom;
        c = '0;
        c.load.read = 1'b1;
        c.load.mdr_in = 1'b1;
        add_step(c, m, '0, m_bus, '0, '0, '0, '0);
        c = '0;
        c.drive.mdr_out = 1'b1;
        c.load.gpr_in[3] = 1'b1;
        add_step(c, '0, '0, m_bus | m_wdata, m, '0, m, '0);
        c = '0;
        c.drive.gpr_out[3] = 1'b1;
        bus_step(c, '0, m);

        // operands into r1 and r2, Y from r1, Z from r2 and the op
        cur_test = 1;
        foreach (ops[n]) begin
            a = $urandom;
            b = $urandom;
            r = alu_model(ops[n], a, b);
            c = '0;
            c.drive.inport_out = 1'b1;
            c.load.gpr_in[1] = 1'b1;
            bus_step(c, a, a);
            c = '0;
            c.drive.inport_out = 1'b1;
            c.load.gpr_in[2] = 1'b1;
            bus_step(c, b, b);
            c = '0;
            c.drive.gpr_out[1] = 1'b1;
            c.load.y_in = 1'b1;
            bus_step(c, '0, a);
            c = '0;
            c.drive.gpr_out[2] = 1'b1;
            c.load.z_in = 1'b1;
            c.op = ops[n];
            bus_step(c, '0, b);
            c = '0;
            c.drive.zlo_out = 1'b1;
            bus_step(c, '0, r[31:0]);
            c = '0;
            c.drive.zhi_out = 1'b1;
            bus_step(c, '0, r[63:32]);
        end

        cur_test = 2;
        p = $urandom;
        q = $urandom;
        c = '0;
        c.drive.inport_out = 1'b1;
        c.load.pc_in = 1'b1;
        bus_step(c, p, p);
        c = '0;
        c.load.pc_increment = 1'b1;
        bus_step(c, '0, '0);
        c = '0;
        c.drive.pc_out = 1'b1;
        c.load.mar_in = 1'b1;
        bus_step(c, '0, p + 32'd1);
        c = '0;
        add_step(c, '0, '0, m_bus | m_addr, '0, p + 32'd1, '0, '0);
        // load beats increment in the same cycle
        c = '0;
        c.drive.inport_out = 1'b1;
        c.load.pc_in = 1'b1;
        c.load.pc_increment = 1'b1;
        bus_step(c, q, q);
        c = '0;
        c.drive.pc_out = 1'b1;
        bus_step(c, '0, q);

        cur_test = 3;
        h = $urandom;
        l = $urandom;
        c = '0;
        c.drive.inport_out = 1'b1;
        c.load.hi_in = 1'b1;
        bus_step(c, h, h);
        c = '0;
        c.drive.inport_out = 1'b1;
        c.load.lo_in = 1'b1;
        bus_step(c, l, l);
        c = '0;
        c.drive.hi_out = 1'b1;
        c.drive.lo_out = 1'b1;
        c.drive.pc_out = 1'b1;
        c.drive.c_out = 1'b1;
        bus_step(c, '0, h);
        c = '0;
        c.drive.gpr_out[3] = 1'b1;
        c.drive.hi_out = 1'b1;
        bus_step(c, '0, m);
        // r5 was never loaded, r3 still wins
        c = '0;
        c.drive.gpr_out[5] = 1'b1;
        c.drive.gpr_out[3] = 1'b1;
        c.drive.inport_out = 1'b1;
        bus_step(c, l, m);
        c = '0;
        c.drive.lo_out = 1'b1;
        c.drive.mdr_out = 1'b1;
        c.drive.inport_out = 1'b1;
        bus_step(c, h, l);
        c = '0;
        bus_step(c, h, '0);

        cur_test = 4;
        i_neg = $urandom | 32'h0004_0000;
        i_pos = $urandom & ~32'h0004_0000;
        c = '0;
        c.drive.inport_out = 1'b1;
        c.load.ir_in = 1'b1;
        bus_step(c, i_neg, i_neg);
        c = '0;
        c.drive.c_out = 1'b1;
        add_step(c, '0, '0, m_bus | m_ir, c_extend(i_neg), '0, '0, i_neg);
        c = '0;
        c.drive.inport_out = 1'b1;
        c.load.ir_in = 1'b1;
        bus_step(c, i_pos, i_pos);
        c = '0;
        c.drive.c_out = 1'b1;
        add_step(c, '0, '0, m_bus | m_ir, c_extend(i_pos), '0, '0, i_pos);

        // mid-run reset, then one drive flag at a time over all of drive_t
        cur_test = 5;
        reset_step();
        w = $urandom | 32'h1;
        for (int f = 0; f < $bits(drive_t); f++) begin
            c = '0;
            c.drive = drive_t'(24'd1 << f);
            // inport is not a register and keeps its input word
            bus_step(c, w, c.drive.inport_out ? w : '0);
        end
        c = '0;
        add_step(c, '0, '0, m_bus | m_addr | m_wdata | m_ir, '0, '0, '0, '0);
    endtask

    task automatic report_mismatch(input string what, input int k,
                                   input word_t got, input word_t exp);
        $display("ERR %0t: %s at step %0d is %h, expected %h", $time, what, k, got, exp);
        errors++;
        test_errors++;
    endtask

    task automatic check_step(input step_t s, input int k);
        if (s.mask[0]) begin
            test_checks++;
            assert (bus_data === s.bus) else report_mismatch("bus_data", k, bus_data, s.bus);
        end
        if (s.mask[1]) begin
            test_checks++;
            assert (mem_addr === s.addr) else report_mismatch("mem_addr", k, mem_addr, s.addr);
        end
        if (s.mask[2]) begin
            test_checks++;
            assert (mem_wdata === s.wdata)
                else report_mismatch("mem_wdata", k, mem_wdata, s.wdata);
        end
        if (s.mask[3]) begin
            test_checks++;
            assert (ir_data === s.ir) else report_mismatch("ir_data", k, ir_data, s.ir);
        end
    endtask

    task automatic finish_test(input int id);
        $display("test %0d %s: %0d checks, %0d errors", id, test_names[id],
                 test_checks, test_errors);
        checks += test_checks;
        tests_run++;
        test_checks = 0;
        test_errors = 0;
    endtask

    // watchdog on clock cycles
    initial begin
        cycles = 0;
        wait (cycle_limit != 0);
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d clock cycles", cycle_limit);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        reset = 1'b1;
        ctrl = '0;
        mem_data_in = '0;
        inport_data = '0;
        void'($urandom(32'hc942));
        build_table();
        cycle_limit = steps.size() * 2 + 10 + 50;
        repeat (10) @(posedge clk);
        foreach (steps[k]) begin
            #1;
            reset = steps[k].rst;
            ctrl = steps[k].ctrl;
            mem_data_in = steps[k].mem;
            inport_data = steps[k].inport;
            // sample just before the next rising edge
            #17;
            check_step(steps[k], k);
            if (k == steps.size() - 1 || steps[k+1].test != steps[k].test) begin
                finish_test(steps[k].test);
            end
            @(posedge clk);
        end
        $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- verilog.f
src/datapath_pkg.sv
src/register_file.sv
src/bus_driver.sv
src/alu.sv
src/special_registers.sv
src/memory_interface.sv
src/datapath.sv
sim/datapath_tb.sv

//--- Makefile
# Verilator build and run of the datapath testbench

VERILATOR ?= verilator
TOP       ?= datapath_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= === PASS ===

SOURCES := $(shell cat $(FILELIST))
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BINARY)
	./$(BINARY) | tee $(LOG)
	@grep -qxF "$(PASS_TEXT)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
